// File: include/cavlc_cfg.svh
`ifndef CAVLC_CFG_SVH
`define CAVLC_CFG_SVH

// --------------------
// block geometry
// --------------------
`define BLOCK_COEFFS 16  // coefficients in one 4x4 block
`define COEFF_W      16  // bits per coefficient

// --------------------
// code word sizing
// --------------------
// the longest run_before string of a block stays below 32 bits
`define CODE_W       32  // accumulated run_before string
`define CODE_LEN_W   6   // holds a bit length up to 32

`endif

// File: src/cavlcResidualPkg.sv
`include "cavlc_cfg.svh"

package cavlcResidualPkg;

    // --------------------
    // coefficients
    // --------------------
    typedef logic signed [`COEFF_W-1:0] coeff_t;
    typedef coeff_t [`BLOCK_COEFFS-1:0] resBlock_t;  // zigzag order with DC at index 0

    // --------------------
    // scan result
    // --------------------
    typedef logic [3:0] runLen_t;                     // zeros below one coefficient
    typedef logic [4:0] zeroCnt_t;                    // counts from 0 to 16
    typedef runLen_t [`BLOCK_COEFFS-2:0] runList_t;   // entry 0 is the highest-frequency nonzero

    typedef struct packed {
        zeroCnt_t totalCoeff;
        zeroCnt_t totalZeros;  // zeros below the highest nonzero coefficient
        runList_t runs;
    } scanResult_t;

endpackage

// File: src/cavlcCodePkg.sv
`include "cavlc_cfg.svh"

package cavlcCodePkg;

    // --------------------
    // code words
    // --------------------
    typedef logic [`CODE_W-1:0]     codeWord_t;  // right aligned, first code in the upper bits
    typedef logic [`CODE_LEN_W-1:0] codeLen_t;

    // --------------------
    // encoded result
    // --------------------
    // also used for a single table entry while encoding
    typedef struct packed {
        codeWord_t code;
        codeLen_t  len;
    } rbCode_t;

endpackage

// File: src/runScanner.sv
`timescale 1ns/10ps
`include "cavlc_cfg.svh"

module runScanner
    import cavlcResidualPkg::*;
(
    input  logic        clk,
    input  logic        enc_rst,
    input  logic        scanStart,
    input  resBlock_t   block,
    output logic        scanDone,
    output scanResult_t scan
);
    resBlock_t   blkReg;
    logic [3:0]  idx;
    logic        busy;
    logic        found;
    runLen_t     zeroRun;
    scanResult_t work;

    coeff_t      curCoeff;
    logic        baseFound;
    runLen_t     baseRun;
    scanResult_t baseWork;
    zeroCnt_t    prevSlot;
    logic        nextFound;
    runLen_t     nextRun;
    scanResult_t nextWork;

    // --------------------
    // one scan step
    // --------------------
    always_comb begin
        curCoeff  = scanStart ? block[`BLOCK_COEFFS-1] : blkReg[idx];  // index 15 comes from the port
        baseFound = scanStart ? 1'b0 : found;
        baseRun   = scanStart ? '0 : zeroRun;
        baseWork  = scanStart ? '0 : work;
        prevSlot  = baseWork.totalCoeff - 5'd1;
        nextFound = baseFound;
        nextRun   = baseRun;
        nextWork  = baseWork;
        if (curCoeff != '0) begin
            if (baseFound) begin
                nextWork.runs[prevSlot[3:0]] = baseRun;  // close the run of the previous nonzero
            end
            nextFound           = 1'b1;
            nextRun             = '0;
            nextWork.totalCoeff = baseWork.totalCoeff + 5'd1;
        end else if (baseFound) begin
            nextRun             = baseRun + 4'd1;
            nextWork.totalZeros = baseWork.totalZeros + 5'd1;
        end
    end

    // --------------------
    // block and results
    // --------------------
    always_ff @(posedge clk) begin
        if (scanStart) begin
            blkReg <= block;
        end
        if (scanStart || busy) begin
            work    <= nextWork;
            zeroRun <= nextRun;
        end
        if (busy && idx == 4'd0) begin
            scan <= nextWork;  // the last open run is dropped here
        end
    end

    // --------------------
    // sequencing
    // --------------------
    always_ff @(posedge clk) begin
        if (enc_rst) begin
            busy     <= 1'b0;
            found    <= 1'b0;
            idx      <= '0;
            scanDone <= 1'b0;
        end else begin
            scanDone <= busy && (idx == 4'd0);
            if (scanStart || busy) begin
                found <= nextFound;
            end
            if (scanStart) begin
                busy <= 1'b1;
                idx  <= 4'(`BLOCK_COEFFS - 2);  // index 15 was handled in the start cycle
            end else if (busy) begin
                if (idx == 4'd0) begin
                    busy <= 1'b0;
                end else begin
                    idx <= idx - 4'd1;
                end
            end
        end
    end

endmodule

// File: src/runBeforeEncoder.sv
`timescale 1ns/10ps

module runBeforeEncoder
    import cavlcResidualPkg::*;
    import cavlcCodePkg::*;
(
    input  logic        clk,
    input  logic        enc_rst,
    input  logic        encLoad,
    input  scanResult_t scan,
    output logic        encDone,
    output rbCode_t     code
);
    runList_t runs;
    zeroCnt_t runCount;
    zeroCnt_t stepCnt;
    zeroCnt_t zerosLeft;
    logic     busy;

    runLen_t  run;
    rbCode_t  stepCode;
    zeroCnt_t nextZeros;
    zeroCnt_t nextCnt;
    logic     loadGo;
    logic     stepGo;

    assign run       = runs[stepCnt[3:0]];
    assign nextZeros = zerosLeft - zeroCnt_t'(run);
    assign nextCnt   = stepCnt + 5'd1;
    assign loadGo    = (scan.totalCoeff > 5'd1) && (scan.totalZeros != '0);
    assign stepGo    = (nextCnt < runCount) && (nextZeros != '0);  // checked after each step

    // --------------------
    // run_before table
    // --------------------
    always_comb begin
        stepCode = '0;
        case (zerosLeft)
            5'd0: stepCode = '0;
            5'd1: begin
                stepCode.len  = 6'd1;
                stepCode.code = (run == 4'd0) ? 32'd1 : 32'd0;
            end
            5'd2: begin
                stepCode.len  = (run == 4'd0) ? 6'd1 : 6'd2;
                stepCode.code = (run == 4'd2) ? 32'd0 : 32'd1;
            end
            5'd3: begin
                stepCode.len  = 6'd2;
                stepCode.code = codeWord_t'(4'd3 - run);
            end
            5'd4: begin
                stepCode.len  = (run < 4'd3) ? 6'd2 : 6'd3;
                stepCode.code = (run < 4'd3) ? codeWord_t'(4'd3 - run) : codeWord_t'(4'd4 - run);
            end
            5'd5: begin
                stepCode.len  = (run < 4'd2) ? 6'd2 : 6'd3;
                stepCode.code = (run < 4'd2) ? codeWord_t'(4'd3 - run) : codeWord_t'(4'd5 - run);
            end
            5'd6: begin
                stepCode.len = (run == 4'd0) ? 6'd2 : 6'd3;
                case (run)
                    4'd0:    stepCode.code = 32'b11;
                    4'd1:    stepCode.code = 32'b000;
                    4'd2:    stepCode.code = 32'b001;
                    4'd3:    stepCode.code = 32'b011;
                    4'd4:    stepCode.code = 32'b010;
                    4'd5:    stepCode.code = 32'b101;
                    default: stepCode.code = 32'b100;
                endcase
            end
            default: begin
                if (run < 4'd7) begin
                    stepCode.len  = 6'd3;
                    stepCode.code = codeWord_t'(4'd7 - run);
                end else begin
                    stepCode.len  = codeLen_t'(run) - 6'd3;  // run-4 zeros then a one
                    stepCode.code = 32'd1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (encLoad) begin
            runs     <= scan.runs;
            runCount <= scan.totalCoeff - 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            busy      <= 1'b0;
            encDone   <= 1'b0;
            stepCnt   <= '0;
            zerosLeft <= '0;
            code      <= '0;
        end else begin
            encDone <= 1'b0;
            if (encLoad) begin
                busy      <= loadGo;
                encDone   <= !loadGo;  // nothing to code finishes right away
                stepCnt   <= '0;
                zerosLeft <= scan.totalZeros;
                code      <= '0;
            end else if (busy) begin
                code.code <= (code.code << stepCode.len) + stepCode.code;
                code.len  <= code.len + stepCode.len;
                zerosLeft <= nextZeros;
                stepCnt   <= nextCnt;
                if (!stepGo) begin
                    busy    <= 1'b0;
                    encDone <= 1'b1;
                end
            end
        end
    end

endmodule

// File: src/cavlcBlockCtrl.sv
`timescale 1ns/10ps

module cavlcBlockCtrl (
    input  logic clk,
    input  logic enc_rst,
    input  logic req,
    output logic ack,
    output logic scanStart,
    input  logic scanDone,
    output logic encLoad,
    input  logic encDone
);
    typedef enum logic [2:0] {
        stIdle,
        stScanning,
        stEncoding,
        stAcknowledging,
        stReleasing
    } ctrlState_t;

    ctrlState_t state;

    // --------------------
    // block sequencing
    // --------------------
    always_ff @(posedge clk) begin
        if (enc_rst) begin
            state     <= stIdle;
            ack       <= 1'b0;
            scanStart <= 1'b0;
            encLoad   <= 1'b0;
        end else begin
            scanStart <= 1'b0;  // start pulses last one cycle
            encLoad   <= 1'b0;
            case (state)
                stIdle: begin
                    if (req) begin
                        state     <= stScanning;
                        scanStart <= 1'b1;
                    end
                end
                stScanning: begin
                    if (scanDone) begin
                        state   <= stEncoding;
                        encLoad <= 1'b1;
                    end
                end
                stEncoding: begin
                    if (encDone) begin
                        state <= stAcknowledging;
                        ack   <= 1'b1;  // result is already held by the encoder
                    end
                end
                stAcknowledging: begin
                    // a requester holding req high stalls here
                    if (!req) begin
                        state <= stReleasing;
                        ack   <= 1'b0;
                    end
                end
                stReleasing: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

// File: src/cavlcRunBeforeTop.sv
`timescale 1ns/10ps

module cavlcRunBeforeTop
    import cavlcResidualPkg::*;
    import cavlcCodePkg::*;
(
    input  logic      clk,
    input  logic      enc_rst,
    input  logic      req,
    input  resBlock_t block,
    output logic      ack,
    output rbCode_t   result
);
    logic        scanStart;
    logic        scanDone;
    logic        encLoad;
    logic        encDone;
    scanResult_t scan;

    cavlcBlockCtrl ctrl (
        .clk       (clk),
        .enc_rst   (enc_rst),
        .req       (req),
        .ack       (ack),
        .scanStart (scanStart),
        .scanDone  (scanDone),
        .encLoad   (encLoad),
        .encDone   (encDone)
    );

    runScanner scanner (
        .clk       (clk),
        .enc_rst   (enc_rst),
        .scanStart (scanStart),
        .block     (block),
        .scanDone  (scanDone),
        .scan      (scan)
    );

    runBeforeEncoder encoder (
        .clk     (clk),
        .enc_rst (enc_rst),
        .encLoad (encLoad),
        .scan    (scan),
        .encDone (encDone),
        .code    (result)
    );

endmodule

// File: tb/cavlcTop_assert.sv
`timescale 1ns/10ps

module cavlcTopAssert
    import cavlcCodePkg::*;
(
    input logic    clk,
    input logic    enc_rst,
    input logic    req,
    input logic    ack,
    input rbCode_t result
);
    int failCount = 0;  // read by the testbench for its summary

    // --------------------
    // handshake
    // --------------------
    ackLowAfterReset: assert property (@(posedge clk) enc_rst |=> !ack)
        else begin
            $error("ack is high in the cycle after reset");
            failCount++;
        end

    // the cycle that raised ack must have seen req high
    ackNeedsReq: assert property (@(posedge clk) disable iff (enc_rst) $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            failCount++;
        end

    resultHeld: assert property (@(posedge clk) disable iff (enc_rst)
        (ack && $past(ack)) |-> $stable(result))
        else begin
            $error("result changed while ack was high");
            failCount++;
        end

    // --------------------
    // ranges
    // --------------------
    lenInRange: assert property (@(posedge clk) disable iff (enc_rst) result.len <= 6'd32)
        else begin
            $error("result length is above 32 bits");
            failCount++;
        end

endmodule

bind cavlcRunBeforeTop cavlcTopAssert chk (
    .clk     (clk),
    .enc_rst (enc_rst),
    .req     (req),
    .ack     (ack),
    .result  (result)
);

// File: tb/cavlcTb.sv
`timescale 1ns/10ps
`include "cavlc_cfg.svh"

module cavlcTb
    import cavlcResidualPkg::*;
    import cavlcCodePkg::*;
;
    typedef struct packed {
        resBlock_t block;
        rbCode_t   expCode;
    } tableEntry_t;

    logic        clk;
    logic        enc_rst;
    logic        req;
    resBlock_t   block;
    logic        ack;
    rbCode_t     result;

    tableEntry_t entries[$];
    integer      seed = 32'hc01a942e;
    logic        tableReady = 1'b0;
    int          valueErrors = 0;
    int          protoErrors = 0;

    cavlcRunBeforeTop uut (
        .clk     (clk),
        .enc_rst (enc_rst),
        .req     (req),
        .block   (block),
        .ack     (ack),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // reference model
    // --------------------
    function automatic string runBeforeBits(int zerosLeft, int run);
        string row;
        string tok;
        int    field;
        tok = "";
        if (zerosLeft > 6 && run >= 7) begin
            repeat (run - 4) tok = {tok, "0"};
            tok = {tok, "1"};
            return tok;
        end
        case (zerosLeft)  // codes for run 0, 1, 2, ... separated by spaces
            1:       row = "1 0";
            2:       row = "1 01 00";
            3:       row = "11 10 01 00";
            4:       row = "11 10 01 001 000";
            5:       row = "11 10 011 010 001 000";
            6:       row = "11 000 001 011 010 101 100";
            default: row = "111 110 101 100 011 010 001";
        endcase
        field = 0;
        for (int i = 0; i < row.len(); i++) begin
            if (row.substr(i, i) == " ") field++;
            else if (field == run) tok = {tok, row.substr(i, i)};
        end
        return tok;
    endfunction

    function automatic rbCode_t refRunBefore(resBlock_t blk);
        int      pos[$];
        int      zerosLeft;
        int      run;
        string   bits;
        rbCode_t res;
        res = '0;
        for (int i = `BLOCK_COEFFS - 1; i >= 0; i--) begin
            if (blk[i] != '0) pos.push_back(i);  // highest frequency first
        end
        if (pos.size() < 2) return res;
        zerosLeft = pos[0] + 1 - pos.size();
        for (int k = 0; k < pos.size() - 1 && zerosLeft > 0; k++) begin
            run  = pos[k] - pos[k + 1] - 1;
            bits = runBeforeBits(zerosLeft, run);
            for (int b = 0; b < bits.len(); b++) begin
                res.code = (res.code << 1) | codeWord_t'(bits.substr(b, b) == "1");
                res.len  = res.len + 6'd1;
            end
            zerosLeft -= run;
        end
        return res;
    endfunction

    // --------------------
    // stimulus table
    // --------------------
    task automatic addEntry(resBlock_t blk, logic useRef, codeWord_t code, codeLen_t len);
        tableEntry_t e;
        rbCode_t     model;
        model = refRunBefore(blk);
        e.block = blk;
        e.expCode.code = useRef ? model.code : code;  // fixed cases carry hand-worked values
        e.expCode.len  = useRef ? model.len : len;
        entries.push_back(e);
    endtask

    task automatic buildTable();
        resBlock_t blk;
        blk = '0;
        addEntry(blk, 1'b0, 32'd0, 6'd0);
        blk[5] = -16'sd3;
        addEntry(blk, 1'b0, 32'd0, 6'd0);
        blk = '0;
        blk[0] = 16'sd9;
        blk[2] = -16'sd1;
        blk[3] = 16'sd2;
        blk[6] = 16'sd1;
        addEntry(blk, 1'b0, 32'b0110, 6'd4);
        blk = '0;
        blk[15] = 16'sd1;
        blk[0] = -16'sd40;
        addEntry(blk, 1'b0, 32'b00000000001, 6'd11);
        blk = '0;
        blk[15] = 16'sd2;
        blk[7] = 16'sd1;
        blk[0] = 16'sd5;
        addEntry(blk, 1'b1, '0, '0);
        blk = '0;
        blk[12] = 16'sd1;
        blk[3] = 16'sd1;
        blk[2] = -16'sd1;
        blk[1] = 16'sd4;
        blk[0] = 16'sd3;
        addEntry(blk, 1'b1, '0, '0);  // zeros left runs out with three coefficients to go
        blk = '0;
        blk[10] = -16'sd7;
        blk[9] = 16'sd1;
        blk[2] = 16'sd1;
        addEntry(blk, 1'b1, '0, '0);
        blk = '0;
        for (int i = 0; i < `BLOCK_COEFFS; i += 2) blk[i] = coeff_t'(i + 1);
        addEntry(blk, 1'b1, '0, '0);
        blk = {`BLOCK_COEFFS{16'sd1}};
        addEntry(blk, 1'b1, '0, '0);
        for (int n = 0; n < 40; n++) begin
            blk = '0;
            for (int i = 0; i < `BLOCK_COEFFS; i++) begin
                if ($unsigned($random(seed)) % 3 == 0) begin
                    blk[i] = coeff_t'($random(seed));
                    if (blk[i] == '0) blk[i] = 16'sd1;
                end
            end
            addEntry(blk, 1'b1, '0, '0);
        end
    endtask

    // --------------------
    // handshake and checks
    // --------------------
    task automatic runBlock(int n);
        tableEntry_t e;
        int          cycles;
        int          hold;
        rbCode_t     held;
        e = entries[n];
        @(negedge clk);
        assert (!ack) else begin
            protoErrors++;
            $display("block %0d: ack was already high before req rose", n);
        end
        block  = e.block;
        req    = 1'b1;
        cycles = 0;
        while (!ack) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles >= 20 && cycles <= 35) else begin
            protoErrors++;
            $display("block %0d: ack came %0d cycles after req", n, cycles);
        end
        assert (result.code == e.expCode.code) else begin
            valueErrors++;
            $display("ERR %0t result.code block %0d expected %h got %h",
                     $time, n, e.expCode.code, result.code);
        end
        assert (result.len == e.expCode.len) else begin
            valueErrors++;
            $display("ERR %0t result.len block %0d expected %0d got %0d",
                     $time, n, e.expCode.len, result.len);
        end
        held = result;
        hold = $unsigned($random(seed)) % 6;  // requester stalls before releasing
        repeat (hold) begin
            @(negedge clk);
            assert (ack) else begin
                protoErrors++;
                $display("block %0d: ack dropped while req was still high", n);
            end
            assert (result == held) else begin
                valueErrors++;
                $display("ERR %0t result block %0d expected %h got %h", $time, n, held, result);
            end
        end
        req = 1'b0;
        @(negedge clk);
        assert (!ack) else begin
            protoErrors++;
            $display("block %0d: ack still high one cycle after req fell", n);
        end
    endtask

    initial begin
        wait (tableReady);
        #(entries.size() * 60 * 100);
        $display("timeout: the DUT stopped answering the handshake");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int total;
        enc_rst = 1'b1;
        req     = 1'b0;
        block   = '0;
        buildTable();
        tableReady = 1'b1;
        repeat (8) @(negedge clk);
        enc_rst = 1'b0;
        @(negedge clk);
        assert (!ack) else begin
            protoErrors++;
            $display("ack is high after reset");
        end
        for (int n = 0; n < entries.size(); n++) runBlock(n);
        total = valueErrors + protoErrors + uut.chk.failCount;
        $display("%0d blocks: %0d value errors, %0d handshake errors, %0d assertion failures",
                 entries.size(), valueErrors, protoErrors, uut.chk.failCount);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
src/cavlcResidualPkg.sv
src/cavlcCodePkg.sv
src/runScanner.sv
src/runBeforeEncoder.sv
src/cavlcBlockCtrl.sv
src/cavlcRunBeforeTop.sv
tb/cavlcTop_assert.sv
tb/cavlcTb.sv
